/* mpram_defines.svh */
`ifndef MPRAM_DEFINES_SVH
`define MPRAM_DEFINES_SVH

// Port counts
`define MPRAM_READ_PORTS  2
`define MPRAM_WRITE_PORTS 2

// Word shape
`define MPRAM_WIDTH 32
`define MPRAM_BYTES 4   // Byte lanes per word

// Array shape, depth is a whole number of banks
`define MPRAM_DEPTH     64
`define MPRAM_BANK_SIZE 16
`define MPRAM_BANKS     4

`endif

/* mpram_mem_pkg.sv */
`include "mpram_defines.svh"

package mpram_mem_pkg;

    // One stored word and its byte lanes
    typedef logic [`MPRAM_WIDTH-1:0] word_t;
    typedef logic [`MPRAM_WIDTH/`MPRAM_BYTES-1:0] byte_t;

    // Byte write enables of one write port
    typedef logic [`MPRAM_BYTES-1:0] byte_en_t;

    // Full word address, bank number in the upper bits
    typedef logic [$clog2(`MPRAM_DEPTH)-1:0] addr_t;

    // Word offset inside one bank
    typedef logic [$clog2(`MPRAM_BANK_SIZE)-1:0] bank_addr_t;

    // Bank number
    typedef logic [$clog2(`MPRAM_BANKS)-1:0] bank_sel_t;

endpackage

/* mpram_ctrl_pkg.sv */
`include "mpram_defines.svh"

package mpram_ctrl_pkg;

    typedef enum logic [0:0] {
        CLEARING = 1'b0,   // Sweeping zeros into the banks
        READY    = 1'b1
    } clear_state_e;

    // One bit wider than the bank offset so it can reach the bank size
    typedef logic [$clog2(`MPRAM_BANK_SIZE):0] clear_count_t;

endpackage

/* mpram_clear_ctrl.sv */
`timescale 1ns/100ps
`include "mpram_defines.svh"

module mpram_clear_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      clearing,
    output mpram_mem_pkg::bank_addr_t clear_addr,
    output logic                      ready
);

    mpram_ctrl_pkg::clear_state_e state;
    mpram_ctrl_pkg::clear_count_t count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mpram_ctrl_pkg::CLEARING;
            count <= '0;
        end else begin
            case (state)
                mpram_ctrl_pkg::CLEARING: begin
                    count <= count + 1'b1;
                    // Last offset written the cycle before
                    if (count == mpram_ctrl_pkg::clear_count_t'(`MPRAM_BANK_SIZE)) begin
                        state <= mpram_ctrl_pkg::READY;
                    end
                end
                default: begin
                    state <= mpram_ctrl_pkg::READY;   // Held until next reset
                end
            endcase
        end
    end

    assign clearing   = (state == mpram_ctrl_pkg::CLEARING);
    assign ready      = (state == mpram_ctrl_pkg::READY);
    assign clear_addr = count[$bits(mpram_mem_pkg::bank_addr_t)-1:0];

    // Ready only after the full sweep, never together with clearing
    a_ready_clear_excl : assert property (
        @(posedge clk) disable iff (rst)
        ready |-> !clearing && count == mpram_ctrl_pkg::clear_count_t'(`MPRAM_BANK_SIZE + 1)
    ) else $error("ERROR: ready=%0b clearing=%0b count=%0d", ready, clearing, count);

endmodule

/* mpram_write_route.sv */
`timescale 1ns/100ps
`include "mpram_defines.svh"

module mpram_write_route (
    input  mpram_mem_pkg::addr_t                               [`MPRAM_WRITE_PORTS-1:0] waddr,
    input  mpram_mem_pkg::byte_en_t                            [`MPRAM_WRITE_PORTS-1:0] we,
    input  mpram_mem_pkg::word_t                               [`MPRAM_WRITE_PORTS-1:0] wdata,
    input  logic                                               clearing,
    input  mpram_mem_pkg::bank_addr_t                          clear_addr,
    output mpram_mem_pkg::bank_addr_t                          [`MPRAM_WRITE_PORTS-1:0] bank_waddr,
    output mpram_mem_pkg::word_t                               [`MPRAM_WRITE_PORTS-1:0] bank_wdata,
    output mpram_mem_pkg::byte_en_t [`MPRAM_BANKS-1:0]         [`MPRAM_WRITE_PORTS-1:0] bank_we
);

    mpram_mem_pkg::bank_sel_t  [`MPRAM_WRITE_PORTS-1:0] wsel;
    mpram_mem_pkg::bank_addr_t [`MPRAM_WRITE_PORTS-1:0] woff;
    logic [`MPRAM_WRITE_PORTS-1:0][`MPRAM_BANKS-1:0]    bank_hit;

    for (genvar p = 0; p < `MPRAM_WRITE_PORTS; p++) begin : g_port
        assign {wsel[p], woff[p]} = waddr[p];
        assign bank_hit[p] = {{(`MPRAM_BANKS-1){1'b0}}, 1'b1} << wsel[p];   // One-hot bank

        if (p == 0) begin : g_clear
            // Port 0 carries the clear sweep
            assign bank_waddr[p] = clearing ? clear_addr : woff[p];
            assign bank_wdata[p] = clearing ? '0 : wdata[p];
        end else begin : g_user
            assign bank_waddr[p] = woff[p];
            assign bank_wdata[p] = wdata[p];
        end
    end

    for (genvar b = 0; b < `MPRAM_BANKS; b++) begin : g_bank
        for (genvar p = 0; p < `MPRAM_WRITE_PORTS; p++) begin : g_we
            if (p == 0) begin : g_clear
                assign bank_we[b][p] = clearing ? '1
                                     : (we[p] & {`MPRAM_BYTES{bank_hit[p][b]}});
            end else begin : g_user
                assign bank_we[b][p] = we[p] & {`MPRAM_BYTES{bank_hit[p][b]}};
            end
        end
    end

endmodule

/* mpram_bank.sv */
`timescale 1ns/100ps
`include "mpram_defines.svh"

module mpram_bank (
    input  logic                                              clk,
    input  logic                                              clearing,
    input  mpram_mem_pkg::bank_addr_t [`MPRAM_WRITE_PORTS-1:0] waddr,
    input  mpram_mem_pkg::word_t      [`MPRAM_WRITE_PORTS-1:0] wdata,
    input  mpram_mem_pkg::byte_en_t   [`MPRAM_WRITE_PORTS-1:0] we,
    input  mpram_mem_pkg::bank_addr_t [`MPRAM_READ_PORTS-1:0]  raddr,
    input  logic                      [`MPRAM_READ_PORTS-1:0]  ren,
    output mpram_mem_pkg::word_t      [`MPRAM_READ_PORTS-1:0]  rdata
);

    // Byte-lane storage, lane 0 in the low bits of the word
    mpram_mem_pkg::byte_t [`MPRAM_BYTES-1:0] mem [`MPRAM_BANK_SIZE];

    // Later port overwrites earlier one on a shared byte
    always_ff @(posedge clk) begin
        for (int p = 0; p < `MPRAM_WRITE_PORTS; p++) begin
            for (int b = 0; b < `MPRAM_BYTES; b++) begin
                if (we[p][b]) begin
                    mem[waddr[p]][b] <=
                        wdata[p][b*$bits(mpram_mem_pkg::byte_t) +: $bits(mpram_mem_pkg::byte_t)];
                end
            end
        end
    end

    // Read-first, old contents seen on a same-cycle write
    always_ff @(posedge clk) begin
        for (int r = 0; r < `MPRAM_READ_PORTS; r++) begin
            if (clearing) begin
                rdata[r] <= '0;
            end else if (ren[r]) begin
                rdata[r] <= mem[raddr[r]];
            end
        end
    end

    // Routed enables must be clean once the sweep is over
    a_we_known : assert property (
        @(posedge clk) disable iff (clearing)
        !$isunknown(we)
    ) else $error("ERROR: we unknown, we=%h", we);

endmodule

/* mpram_read_select.sv */
`timescale 1ns/100ps
`include "mpram_defines.svh"

module mpram_read_select (
    input  logic                                                  clk,
    input  logic                 [`MPRAM_READ_PORTS-1:0]          en,
    input  mpram_mem_pkg::addr_t [`MPRAM_READ_PORTS-1:0]          raddr,
    input  mpram_mem_pkg::word_t [`MPRAM_BANKS-1:0]
                                 [`MPRAM_READ_PORTS-1:0]          bank_rdata,
    output mpram_mem_pkg::word_t [`MPRAM_READ_PORTS-1:0]          rdata
);

    mpram_mem_pkg::bank_sel_t [`MPRAM_READ_PORTS-1:0] sel_q;

    // Captured at the same edge as the bank read register
    always_ff @(posedge clk) begin
        for (int r = 0; r < `MPRAM_READ_PORTS; r++) begin
            if (en[r]) begin
                sel_q[r] <= raddr[r][$bits(mpram_mem_pkg::addr_t)-1 -:
                                     $bits(mpram_mem_pkg::bank_sel_t)];
            end
        end
    end

    for (genvar r = 0; r < `MPRAM_READ_PORTS; r++) begin : g_port
        assign rdata[r] = bank_rdata[sel_q[r]][r];

        // Output hold relies on the index staying put while idle
        a_sel_hold : assert property (
            @(posedge clk)
            !en[r] && !$isunknown(sel_q[r]) |=> $stable(sel_q[r])
        ) else $error("ERROR: sel_q[%0d] changed while idle, now %h", r, sel_q[r]);
    end

endmodule

/* mpram_top.sv */
`timescale 1ns/100ps
`include "mpram_defines.svh"

module mpram_top (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                      [`MPRAM_READ_PORTS-1:0]  en,
    input  mpram_mem_pkg::addr_t      [`MPRAM_READ_PORTS-1:0]  raddr,
    input  mpram_mem_pkg::addr_t      [`MPRAM_WRITE_PORTS-1:0] waddr,
    input  mpram_mem_pkg::byte_en_t   [`MPRAM_WRITE_PORTS-1:0] we,
    input  mpram_mem_pkg::word_t      [`MPRAM_WRITE_PORTS-1:0] wdata,
    output mpram_mem_pkg::word_t      [`MPRAM_READ_PORTS-1:0]  rdata,
    output logic                                              ready
);

    logic                                                          clearing;
    mpram_mem_pkg::bank_addr_t                                     clear_addr;
    mpram_mem_pkg::bank_addr_t [`MPRAM_WRITE_PORTS-1:0]            bank_waddr;
    mpram_mem_pkg::word_t      [`MPRAM_WRITE_PORTS-1:0]            bank_wdata;
    mpram_mem_pkg::byte_en_t   [`MPRAM_BANKS-1:0][`MPRAM_WRITE_PORTS-1:0] bank_we;
    mpram_mem_pkg::bank_sel_t  [`MPRAM_READ_PORTS-1:0]             rsel;
    mpram_mem_pkg::bank_addr_t [`MPRAM_READ_PORTS-1:0]             roff;
    logic [`MPRAM_BANKS-1:0][`MPRAM_READ_PORTS-1:0]                bank_ren;
    mpram_mem_pkg::word_t      [`MPRAM_BANKS-1:0][`MPRAM_READ_PORTS-1:0] bank_rdata;

    mpram_clear_ctrl i_clear_ctrl (
        .clk        (clk),
        .rst        (rst),
        .clearing   (clearing),
        .clear_addr (clear_addr),
        .ready      (ready)
    );

    mpram_write_route i_write_route (
        .waddr      (waddr),
        .we         (we),
        .wdata      (wdata),
        .clearing   (clearing),
        .clear_addr (clear_addr),
        .bank_waddr (bank_waddr),
        .bank_wdata (bank_wdata),
        .bank_we    (bank_we)
    );

    for (genvar r = 0; r < `MPRAM_READ_PORTS; r++) begin : g_rd
        assign {rsel[r], roff[r]} = raddr[r];
    end

    for (genvar b = 0; b < `MPRAM_BANKS; b++) begin : g_bank
        for (genvar r = 0; r < `MPRAM_READ_PORTS; r++) begin : g_ren
            assign bank_ren[b][r] = en[r] && (rsel[r] == b);   // Only the addressed bank reads
        end

        mpram_bank i_bank (
            .clk      (clk),
            .clearing (clearing),
            .waddr    (bank_waddr),
            .wdata    (bank_wdata),
            .we       (bank_we[b]),
            .raddr    (roff),
            .ren      (bank_ren[b]),
            .rdata    (bank_rdata[b])
        );
    end

    mpram_read_select i_read_select (
        .clk        (clk),
        .en         (en),
        .raddr      (raddr),
        .bank_rdata (bank_rdata),
        .rdata      (rdata)
    );

endmodule

/* tb_mpram.sv */
`timescale 1ns/100ps
`include "mpram_defines.svh"

module tb_mpram;

    localparam int cycle_limit = 3000;   // About twice the length of all tests

    logic                                             clk;
    logic                                             rst;
    logic                    [`MPRAM_READ_PORTS-1:0]  en;
    mpram_mem_pkg::addr_t    [`MPRAM_READ_PORTS-1:0]  raddr;
    mpram_mem_pkg::addr_t    [`MPRAM_WRITE_PORTS-1:0] waddr;
    mpram_mem_pkg::byte_en_t [`MPRAM_WRITE_PORTS-1:0] we;
    mpram_mem_pkg::word_t    [`MPRAM_WRITE_PORTS-1:0] wdata;
    mpram_mem_pkg::word_t    [`MPRAM_READ_PORTS-1:0]  rdata;
    logic                                             ready;

    // Reference model state
    mpram_mem_pkg::word_t                           shadow [`MPRAM_DEPTH];
    mpram_mem_pkg::word_t                           last_word [`MPRAM_READ_PORTS];
    logic                 [`MPRAM_READ_PORTS-1:0]   have_last;
    logic                 [`MPRAM_READ_PORTS-1:0]   exp_valid_next;
    logic                 [`MPRAM_READ_PORTS-1:0]   exp_valid;
    mpram_mem_pkg::word_t [`MPRAM_READ_PORTS-1:0]   exp_word_next;
    mpram_mem_pkg::word_t [`MPRAM_READ_PORTS-1:0]   exp_word;
    logic                                           ready_seen;
    int                                             value_errors;
    int                                             other_errors;
    int                                             cycle_count;
    int unsigned                                    seed_draw;

    mpram_top i_mpram_top (
        .clk   (clk),
        .rst   (rst),
        .en    (en),
        .raddr (raddr),
        .waddr (waddr),
        .we    (we),
        .wdata (wdata),
        .rdata (rdata),
        .ready (ready)
    );

    always #5 clk = ~clk;

    // Byte-lane write of one port onto the old word
    function automatic mpram_mem_pkg::word_t merged_word(
        input mpram_mem_pkg::word_t    old_w,
        input mpram_mem_pkg::word_t    new_w,
        input mpram_mem_pkg::byte_en_t be
    );
        mpram_mem_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < `MPRAM_BYTES; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic mpram_mem_pkg::word_t addr_pattern(input int a);
        return mpram_mem_pkg::word_t'((a + 1) * 32'h9e37_79b9);   // Unique per address
    endfunction

    // Read-first expectations, then port 0 and port 1 writes in order
    task automatic record_cycle();
        for (int r = 0; r < `MPRAM_READ_PORTS; r++) begin
            if (en[r]) begin
                last_word[r] = shadow[raddr[r]];
                have_last[r] = 1'b1;
            end
            exp_valid_next[r] = have_last[r];
            exp_word_next[r]  = last_word[r];   // Hold value while idle
        end
        for (int p = 0; p < `MPRAM_WRITE_PORTS; p++) begin
            shadow[waddr[p]] = merged_word(shadow[waddr[p]], wdata[p], we[p]);
        end
    endtask

    task automatic begin_cycle();
        @(negedge clk);
        en    = '0;
        raddr = '0;
        waddr = '0;
        we    = '0;
        wdata = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            begin_cycle();
            record_cycle();
        end
    endtask

    task automatic read_all_words();
        for (int a = 0; a < `MPRAM_DEPTH; a++) begin
            begin_cycle();
            en       = '1;
            raddr[0] = mpram_mem_pkg::addr_t'(a);
            raddr[1] = mpram_mem_pkg::addr_t'(`MPRAM_DEPTH - 1 - a);
            record_cycle();
        end
    endtask

    task automatic check_reset_release();
        repeat (4) begin
            @(negedge clk);
            assert (ready === 1'b0) else begin
                $display("ERROR: ready expected %h got %h during reset", 1'b0, ready);
                value_errors++;
            end
        end
        rst = 1'b0;
        for (int i = 1; i <= `MPRAM_BANK_SIZE + 1; i++) begin
            @(negedge clk);
            assert (ready === (i == `MPRAM_BANK_SIZE + 1)) else begin
                $display("ERROR: ready expected %h got %h after edge %0d",
                         (i == `MPRAM_BANK_SIZE + 1), ready, i);
                value_errors++;
            end
        end
        ready_seen = 1'b1;
    endtask

    task automatic check_full_words();
        for (int a = 0; a < `MPRAM_DEPTH / 2; a++) begin
            begin_cycle();
            we       = '1;
            waddr[0] = mpram_mem_pkg::addr_t'(a);
            wdata[0] = addr_pattern(a);
            waddr[1] = mpram_mem_pkg::addr_t'(a + `MPRAM_DEPTH / 2);
            wdata[1] = addr_pattern(a + `MPRAM_DEPTH / 2);
            record_cycle();
        end
        read_all_words();
    endtask

    task automatic check_byte_enables();
        int p;
        for (int a = 0; a < `MPRAM_DEPTH; a++) begin
            begin_cycle();
            p        = a % 2;
            we[p]    = mpram_mem_pkg::byte_en_t'(a % 15 + 1);   // Every nonzero mask
            waddr[p] = mpram_mem_pkg::addr_t'(a);
            wdata[p] = $urandom();
            record_cycle();
        end
        read_all_words();
    endtask

    task automatic check_port_collision();
        mpram_mem_pkg::addr_t a;
        for (int k = 0; k < 16; k++) begin
            a = mpram_mem_pkg::addr_t'((k * 5) % `MPRAM_DEPTH);
            begin_cycle();
            waddr[0] = a;
            waddr[1] = a;
            we[0]    = (k % 2 == 0) ? 4'b0111 : 4'b1011;
            we[1]    = (k % 2 == 0) ? 4'b1110 : 4'b0011;
            wdata[0] = $urandom();
            wdata[1] = $urandom();
            record_cycle();
            begin_cycle();
            en       = '1;
            raddr[0] = a;
            raddr[1] = a;
            record_cycle();
        end
    endtask

    task automatic check_read_first();
        mpram_mem_pkg::addr_t a;
        for (int k = 0; k < 8; k++) begin
            a = mpram_mem_pkg::addr_t'(k * 9);
            begin_cycle();
            we[0]    = '1;
            waddr[0] = a;
            wdata[0] = $urandom();
            record_cycle();
            begin_cycle();
            we[1]    = '1;
            waddr[1] = a;
            wdata[1] = $urandom();
            en       = '1;
            raddr[0] = a;
            raddr[1] = a;
            record_cycle();
            idle_cycles(2);   // rdata must hold the old word
            begin_cycle();
            en[k % 2]    = 1'b1;
            raddr[k % 2] = a;
            record_cycle();
        end
    endtask

    task automatic run_random_traffic(input int n);
        repeat (n) begin
            begin_cycle();
            for (int r = 0; r < `MPRAM_READ_PORTS; r++) begin
                en[r]    = $urandom_range(1, 0);
                raddr[r] = mpram_mem_pkg::addr_t'($urandom());
            end
            for (int p = 0; p < `MPRAM_WRITE_PORTS; p++) begin
                we[p]    = mpram_mem_pkg::byte_en_t'($urandom());
                waddr[p] = mpram_mem_pkg::addr_t'($urandom());
                wdata[p] = $urandom();
            end
            record_cycle();
        end
    endtask

    always @(posedge clk) begin
        exp_valid <= exp_valid_next;
        exp_word  <= exp_word_next;
    end

    // Compare one cycle after each read, and keep checking the held value
    always @(negedge clk) begin
        for (int r = 0; r < `MPRAM_READ_PORTS; r++) begin
            if (exp_valid[r]) begin
                assert (rdata[r] === exp_word[r]) else begin
                    $display("ERROR: rdata[%0d] expected %h got %h", r, exp_word[r], rdata[r]);
                    value_errors++;
                end
            end
        end
        if (ready_seen) begin
            assert (ready === 1'b1) else begin
                $display("ERROR: ready expected %h got %h", 1'b1, ready);
                value_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            other_errors++;
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        seed_draw = $urandom(32'hc13f8db2);
        clk       = 1'b0;
        rst       = 1'b1;
        en        = '0;
        raddr     = '0;
        waddr     = '0;
        we        = '0;
        wdata     = '0;
        for (int a = 0; a < `MPRAM_DEPTH; a++) begin
            shadow[a] = '0;   // Contents after the clear
        end
        for (int r = 0; r < `MPRAM_READ_PORTS; r++) begin
            last_word[r] = '0;
        end
        have_last      = '0;
        exp_valid_next = '0;
        exp_valid      = '0;
        exp_word_next  = '0;
        exp_word       = '0;
        ready_seen     = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        cycle_count    = 0;

        check_reset_release();
        read_all_words();
        check_full_words();
        check_byte_enables();
        check_port_collision();
        check_read_first();
        run_random_traffic(1000);
        idle_cycles(4);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
mpram_mem_pkg.sv
mpram_ctrl_pkg.sv
mpram_clear_ctrl.sv
mpram_write_route.sv
mpram_bank.sv
mpram_read_select.sv
mpram_top.sv
tb_mpram.sv

/* Bender.yml */
package:
  name: mpram

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mpram_mem_pkg.sv
      - mpram_ctrl_pkg.sv
      - mpram_clear_ctrl.sv
      - mpram_write_route.sv
      - mpram_bank.sv
      - mpram_read_select.sv
      - mpram_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mpram.sv
